// ==== hw/axi_xbar_pkg.sv ====
/* AXI4 field widths shared by the crossbar RTL and its testbench.
   Referenced by scoped name from each file that needs them. */
`default_nettype none

package axi_xbar_pkg;

    localparam int id_width    = 4;
    localparam int addr_width  = 64;
    localparam int data_width  = 64;
    // one strobe bit per data byte
    localparam int strb_width  = data_width / 8;
    localparam int len_width   = 8;
    localparam int size_width  = 3;
    localparam int burst_width = 2;
    localparam int prot_width  = 3;
    localparam int resp_width  = 2;

endpackage

`default_nettype wire

// ==== hw/port_select.sv ====
/* Turns reset and the write/read select words into a granted lane and an
   active flag per direction. Lowest set bit wins. */
`timescale 1ns/1ps
`default_nettype none

module port_select #(
    parameter int slave_count = 3
) (
    input  logic                   reset,
    input  logic [slave_count-1:0] wr_select,
    input  logic [slave_count-1:0] rd_select,
    output logic [(slave_count > 1 ? $clog2(slave_count) : 1)-1:0] wr_lane,
    output logic                   wr_active,
    output logic [(slave_count > 1 ? $clog2(slave_count) : 1)-1:0] rd_lane,
    output logic                   rd_active
);

    localparam int lane_width = slave_count > 1 ? $clog2(slave_count) : 1;

    // msb is the active flag and the rest is the lane index
    function automatic logic [lane_width:0] encode(input logic [slave_count-1:0] sel);
        logic [lane_width:0] result;
        result = '0;
        // walk down so the lowest set bit is written last
        for (int i = slave_count - 1; i >= 0; i--) begin
            if (sel[i]) begin
                result = {1'b1, lane_width'(i)};
            end
        end
        return result;
    endfunction

    always_comb begin
        if (reset) begin
            {wr_active, wr_lane} = '0;
            {rd_active, rd_lane} = '0;
        end else begin
            {wr_active, wr_lane} = encode(wr_select);
            {rd_active, rd_lane} = encode(rd_select);
        end
    end

endmodule

`default_nettype wire

// ==== hw/write_router.sv ====
/* Fans the master AW and W channels out to the granted slave lane and
   merges that lane's B response back. Idle values when no lane is active. */
`timescale 1ns/1ps
`default_nettype none

module write_router #(
    parameter int slave_count = 3
) (
    input  logic [(slave_count > 1 ? $clog2(slave_count) : 1)-1:0] wr_lane,
    input  logic wr_active,

    input  logic [axi_xbar_pkg::id_width-1:0]    master_aw_id,
    input  logic [axi_xbar_pkg::addr_width-1:0]  master_aw_addr,
    input  logic [axi_xbar_pkg::len_width-1:0]   master_aw_len,
    input  logic [axi_xbar_pkg::size_width-1:0]  master_aw_size,
    input  logic [axi_xbar_pkg::burst_width-1:0] master_aw_burst,
    input  logic [axi_xbar_pkg::prot_width-1:0]  master_aw_prot,
    input  logic                                 master_aw_valid,
    output logic                                 master_aw_ready,
    input  logic [axi_xbar_pkg::data_width-1:0]  master_w_data,
    input  logic [axi_xbar_pkg::strb_width-1:0]  master_w_strb,
    input  logic                                 master_w_last,
    input  logic                                 master_w_valid,
    output logic                                 master_w_ready,
    output logic [axi_xbar_pkg::id_width-1:0]    master_b_id,
    output logic [axi_xbar_pkg::resp_width-1:0]  master_b_resp,
    output logic                                 master_b_valid,
    input  logic                                 master_b_ready,

    output logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_aw_id,
    output logic [slave_count*axi_xbar_pkg::addr_width-1:0]  slave_aw_addr,
    output logic [slave_count*axi_xbar_pkg::len_width-1:0]   slave_aw_len,
    output logic [slave_count*axi_xbar_pkg::size_width-1:0]  slave_aw_size,
    output logic [slave_count*axi_xbar_pkg::burst_width-1:0] slave_aw_burst,
    output logic [slave_count*axi_xbar_pkg::prot_width-1:0]  slave_aw_prot,
    output logic [slave_count-1:0]                           slave_aw_valid,
    input  logic [slave_count-1:0]                           slave_aw_ready,
    output logic [slave_count*axi_xbar_pkg::data_width-1:0]  slave_w_data,
    output logic [slave_count*axi_xbar_pkg::strb_width-1:0]  slave_w_strb,
    output logic [slave_count-1:0]                           slave_w_last,
    output logic [slave_count-1:0]                           slave_w_valid,
    input  logic [slave_count-1:0]                           slave_w_ready,
    input  logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_b_id,
    input  logic [slave_count*axi_xbar_pkg::resp_width-1:0]  slave_b_resp,
    input  logic [slave_count-1:0]                           slave_b_valid,
    output logic [slave_count-1:0]                           slave_b_ready
);

    localparam int id_w    = axi_xbar_pkg::id_width;
    localparam int addr_w  = axi_xbar_pkg::addr_width;
    localparam int len_w   = axi_xbar_pkg::len_width;
    localparam int size_w  = axi_xbar_pkg::size_width;
    localparam int burst_w = axi_xbar_pkg::burst_width;
    localparam int prot_w  = axi_xbar_pkg::prot_width;
    localparam int data_w  = axi_xbar_pkg::data_width;
    localparam int strb_w  = axi_xbar_pkg::strb_width;
    localparam int resp_w  = axi_xbar_pkg::resp_width;

    always_comb begin
        // non-granted lanes stay at zero
        slave_aw_id    = '0;
        slave_aw_addr  = '0;
        slave_aw_len   = '0;
        slave_aw_size  = '0;
        slave_aw_burst = '0;
        slave_aw_prot  = '0;
        slave_aw_valid = '0;
        slave_w_data   = '0;
        slave_w_strb   = '0;
        slave_w_last   = '0;
        slave_w_valid  = '0;
        slave_b_ready  = '0;

        // idle absorbs requests and gives no response
        master_aw_ready = 1'b1;
        master_w_ready  = 1'b1;
        master_b_id     = '0;
        master_b_resp   = '0;
        master_b_valid  = 1'b0;

        if (wr_active) begin
            slave_aw_id[wr_lane*id_w +: id_w]          = master_aw_id;
            slave_aw_addr[wr_lane*addr_w +: addr_w]    = master_aw_addr;
            slave_aw_len[wr_lane*len_w +: len_w]       = master_aw_len;
            slave_aw_size[wr_lane*size_w +: size_w]    = master_aw_size;
            slave_aw_burst[wr_lane*burst_w +: burst_w] = master_aw_burst;
            slave_aw_prot[wr_lane*prot_w +: prot_w]    = master_aw_prot;
            slave_aw_valid[wr_lane]                    = master_aw_valid;
            slave_w_data[wr_lane*data_w +: data_w]     = master_w_data;
            slave_w_strb[wr_lane*strb_w +: strb_w]     = master_w_strb;
            slave_w_last[wr_lane]                      = master_w_last;
            slave_w_valid[wr_lane]                     = master_w_valid;
            slave_b_ready[wr_lane]                     = master_b_ready;

            master_aw_ready = slave_aw_ready[wr_lane];
            master_w_ready  = slave_w_ready[wr_lane];
            master_b_id     = slave_b_id[wr_lane*id_w +: id_w];
            master_b_resp   = slave_b_resp[wr_lane*resp_w +: resp_w];
            master_b_valid  = slave_b_valid[wr_lane];
        end
    end

endmodule

`default_nettype wire

// ==== hw/read_router.sv ====
/* Fans the master AR channel out to the granted slave lane and merges that
   lane's R channel back. Idle values when no lane is active. */
`timescale 1ns/1ps
`default_nettype none

module read_router #(
    parameter int slave_count = 3
) (
    input  logic [(slave_count > 1 ? $clog2(slave_count) : 1)-1:0] rd_lane,
    input  logic rd_active,

    input  logic [axi_xbar_pkg::id_width-1:0]    master_ar_id,
    input  logic [axi_xbar_pkg::addr_width-1:0]  master_ar_addr,
    input  logic [axi_xbar_pkg::len_width-1:0]   master_ar_len,
    input  logic [axi_xbar_pkg::size_width-1:0]  master_ar_size,
    input  logic [axi_xbar_pkg::burst_width-1:0] master_ar_burst,
    input  logic [axi_xbar_pkg::prot_width-1:0]  master_ar_prot,
    input  logic                                 master_ar_valid,
    output logic                                 master_ar_ready,
    output logic [axi_xbar_pkg::id_width-1:0]    master_r_id,
    output logic [axi_xbar_pkg::data_width-1:0]  master_r_data,
    output logic [axi_xbar_pkg::resp_width-1:0]  master_r_resp,
    output logic                                 master_r_last,
    output logic                                 master_r_valid,
    input  logic                                 master_r_ready,

    output logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_ar_id,
    output logic [slave_count*axi_xbar_pkg::addr_width-1:0]  slave_ar_addr,
    output logic [slave_count*axi_xbar_pkg::len_width-1:0]   slave_ar_len,
    output logic [slave_count*axi_xbar_pkg::size_width-1:0]  slave_ar_size,
    output logic [slave_count*axi_xbar_pkg::burst_width-1:0] slave_ar_burst,
    output logic [slave_count*axi_xbar_pkg::prot_width-1:0]  slave_ar_prot,
    output logic [slave_count-1:0]                           slave_ar_valid,
    input  logic [slave_count-1:0]                           slave_ar_ready,
    input  logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_r_id,
    input  logic [slave_count*axi_xbar_pkg::data_width-1:0]  slave_r_data,
    input  logic [slave_count*axi_xbar_pkg::resp_width-1:0]  slave_r_resp,
    input  logic [slave_count-1:0]                           slave_r_last,
    input  logic [slave_count-1:0]                           slave_r_valid,
    output logic [slave_count-1:0]                           slave_r_ready
);

    localparam int id_w    = axi_xbar_pkg::id_width;
    localparam int addr_w  = axi_xbar_pkg::addr_width;
    localparam int len_w   = axi_xbar_pkg::len_width;
    localparam int size_w  = axi_xbar_pkg::size_width;
    localparam int burst_w = axi_xbar_pkg::burst_width;
    localparam int prot_w  = axi_xbar_pkg::prot_width;
    localparam int data_w  = axi_xbar_pkg::data_width;
    localparam int resp_w  = axi_xbar_pkg::resp_width;

    always_comb begin
        slave_ar_id    = '0;
        slave_ar_addr  = '0;
        slave_ar_len   = '0;
        slave_ar_size  = '0;
        slave_ar_burst = '0;
        slave_ar_prot  = '0;
        slave_ar_valid = '0;
        slave_r_ready  = '0;

        // idle accepts ar and never presents a read beat
        master_ar_ready = 1'b1;
        master_r_id     = '0;
        master_r_data   = '0;
        master_r_resp   = '0;
        master_r_last   = 1'b0;
        master_r_valid  = 1'b0;

        if (rd_active) begin
            slave_ar_id[rd_lane*id_w +: id_w]          = master_ar_id;
            slave_ar_addr[rd_lane*addr_w +: addr_w]    = master_ar_addr;
            slave_ar_len[rd_lane*len_w +: len_w]       = master_ar_len;
            slave_ar_size[rd_lane*size_w +: size_w]    = master_ar_size;
            slave_ar_burst[rd_lane*burst_w +: burst_w] = master_ar_burst;
            slave_ar_prot[rd_lane*prot_w +: prot_w]    = master_ar_prot;
            slave_ar_valid[rd_lane]                    = master_ar_valid;
            slave_r_ready[rd_lane]                     = master_r_ready;

            master_ar_ready = slave_ar_ready[rd_lane];
            master_r_id     = slave_r_id[rd_lane*id_w +: id_w];
            master_r_data   = slave_r_data[rd_lane*data_w +: data_w];
            master_r_resp   = slave_r_resp[rd_lane*resp_w +: resp_w];
            master_r_last   = slave_r_last[rd_lane];
            master_r_valid  = slave_r_valid[rd_lane];
        end
    end

endmodule

`default_nettype wire

// ==== hw/axi_crossbar.sv ====
/* AXI4 one-master crossbar top. Write and read select words steer the
   channels to one slave lane each, purely combinational. */
`timescale 1ns/1ps
`default_nettype none

module axi_crossbar #(
    parameter int slave_count = 3
) (
    input  logic                   reset,
    input  logic [slave_count-1:0] wr_select,
    input  logic [slave_count-1:0] rd_select,

    input  logic [axi_xbar_pkg::id_width-1:0]    master_aw_id,
    input  logic [axi_xbar_pkg::addr_width-1:0]  master_aw_addr,
    input  logic [axi_xbar_pkg::len_width-1:0]   master_aw_len,
    input  logic [axi_xbar_pkg::size_width-1:0]  master_aw_size,
    input  logic [axi_xbar_pkg::burst_width-1:0] master_aw_burst,
    input  logic [axi_xbar_pkg::prot_width-1:0]  master_aw_prot,
    input  logic                                 master_aw_valid,
    output logic                                 master_aw_ready,
    input  logic [axi_xbar_pkg::data_width-1:0]  master_w_data,
    input  logic [axi_xbar_pkg::strb_width-1:0]  master_w_strb,
    input  logic                                 master_w_last,
    input  logic                                 master_w_valid,
    output logic                                 master_w_ready,
    output logic [axi_xbar_pkg::id_width-1:0]    master_b_id,
    output logic [axi_xbar_pkg::resp_width-1:0]  master_b_resp,
    output logic                                 master_b_valid,
    input  logic                                 master_b_ready,

    input  logic [axi_xbar_pkg::id_width-1:0]    master_ar_id,
    input  logic [axi_xbar_pkg::addr_width-1:0]  master_ar_addr,
    input  logic [axi_xbar_pkg::len_width-1:0]   master_ar_len,
    input  logic [axi_xbar_pkg::size_width-1:0]  master_ar_size,
    input  logic [axi_xbar_pkg::burst_width-1:0] master_ar_burst,
    input  logic [axi_xbar_pkg::prot_width-1:0]  master_ar_prot,
    input  logic                                 master_ar_valid,
    output logic                                 master_ar_ready,
    output logic [axi_xbar_pkg::id_width-1:0]    master_r_id,
    output logic [axi_xbar_pkg::data_width-1:0]  master_r_data,
    output logic [axi_xbar_pkg::resp_width-1:0]  master_r_resp,
    output logic                                 master_r_last,
    output logic                                 master_r_valid,
    input  logic                                 master_r_ready,

    // slave side with lane k in slice k
    output logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_aw_id,
    output logic [slave_count*axi_xbar_pkg::addr_width-1:0]  slave_aw_addr,
    output logic [slave_count*axi_xbar_pkg::len_width-1:0]   slave_aw_len,
    output logic [slave_count*axi_xbar_pkg::size_width-1:0]  slave_aw_size,
    output logic [slave_count*axi_xbar_pkg::burst_width-1:0] slave_aw_burst,
    output logic [slave_count*axi_xbar_pkg::prot_width-1:0]  slave_aw_prot,
    output logic [slave_count-1:0]                           slave_aw_valid,
    input  logic [slave_count-1:0]                           slave_aw_ready,
    output logic [slave_count*axi_xbar_pkg::data_width-1:0]  slave_w_data,
    output logic [slave_count*axi_xbar_pkg::strb_width-1:0]  slave_w_strb,
    output logic [slave_count-1:0]                           slave_w_last,
    output logic [slave_count-1:0]                           slave_w_valid,
    input  logic [slave_count-1:0]                           slave_w_ready,
    input  logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_b_id,
    input  logic [slave_count*axi_xbar_pkg::resp_width-1:0]  slave_b_resp,
    input  logic [slave_count-1:0]                           slave_b_valid,
    output logic [slave_count-1:0]                           slave_b_ready,

    output logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_ar_id,
    output logic [slave_count*axi_xbar_pkg::addr_width-1:0]  slave_ar_addr,
    output logic [slave_count*axi_xbar_pkg::len_width-1:0]   slave_ar_len,
    output logic [slave_count*axi_xbar_pkg::size_width-1:0]  slave_ar_size,
    output logic [slave_count*axi_xbar_pkg::burst_width-1:0] slave_ar_burst,
    output logic [slave_count*axi_xbar_pkg::prot_width-1:0]  slave_ar_prot,
    output logic [slave_count-1:0]                           slave_ar_valid,
    input  logic [slave_count-1:0]                           slave_ar_ready,
    input  logic [slave_count*axi_xbar_pkg::id_width-1:0]    slave_r_id,
    input  logic [slave_count*axi_xbar_pkg::data_width-1:0]  slave_r_data,
    input  logic [slave_count*axi_xbar_pkg::resp_width-1:0]  slave_r_resp,
    input  logic [slave_count-1:0]                           slave_r_last,
    input  logic [slave_count-1:0]                           slave_r_valid,
    output logic [slave_count-1:0]                           slave_r_ready
);

    localparam int lane_width = slave_count > 1 ? $clog2(slave_count) : 1;

    // granted lane per direction
    logic [lane_width-1:0] wr_lane;
    logic                  wr_active;
    logic [lane_width-1:0] rd_lane;
    logic                  rd_active;

    port_select #(
        .slave_count(slave_count)
    ) i_port_select (.*);

    write_router #(
        .slave_count(slave_count)
    ) i_write_router (.*);

    read_router #(
        .slave_count(slave_count)
    ) i_read_router (.*);

endmodule

`default_nettype wire

// ==== verification/xbar_checker.sv ====
/* Crossbar checker. Predicts every DUT output from the DUT inputs on each
   falling clock edge, reports mismatches and counts them. */
`timescale 1ns/1ps
`default_nettype none

module xbar_checker #(
    parameter int slave_count = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic [slave_count-1:0] wr_select, rd_select,

    input  logic [axi_xbar_pkg::id_width-1:0] master_aw_id, master_b_id,
        master_ar_id, master_r_id,
    input  logic [axi_xbar_pkg::addr_width-1:0]  master_aw_addr, master_ar_addr,
    input  logic [axi_xbar_pkg::len_width-1:0]   master_aw_len, master_ar_len,
    input  logic [axi_xbar_pkg::size_width-1:0]  master_aw_size, master_ar_size,
    input  logic [axi_xbar_pkg::burst_width-1:0] master_aw_burst, master_ar_burst,
    input  logic [axi_xbar_pkg::prot_width-1:0]  master_aw_prot, master_ar_prot,
    input  logic [axi_xbar_pkg::data_width-1:0]  master_w_data, master_r_data,
    input  logic [axi_xbar_pkg::strb_width-1:0]  master_w_strb,
    input  logic [axi_xbar_pkg::resp_width-1:0]  master_b_resp, master_r_resp,
    input  logic master_aw_valid, master_aw_ready, master_w_last, master_w_valid,
        master_w_ready, master_b_valid, master_b_ready, master_ar_valid,
        master_ar_ready, master_r_last, master_r_valid, master_r_ready,

    input  logic [slave_count*axi_xbar_pkg::id_width-1:0] slave_aw_id, slave_b_id,
        slave_ar_id, slave_r_id,
    input  logic [slave_count*axi_xbar_pkg::addr_width-1:0]  slave_aw_addr, slave_ar_addr,
    input  logic [slave_count*axi_xbar_pkg::len_width-1:0]   slave_aw_len, slave_ar_len,
    input  logic [slave_count*axi_xbar_pkg::size_width-1:0]  slave_aw_size, slave_ar_size,
    input  logic [slave_count*axi_xbar_pkg::burst_width-1:0] slave_aw_burst, slave_ar_burst,
    input  logic [slave_count*axi_xbar_pkg::prot_width-1:0]  slave_aw_prot, slave_ar_prot,
    input  logic [slave_count*axi_xbar_pkg::data_width-1:0]  slave_w_data, slave_r_data,
    input  logic [slave_count*axi_xbar_pkg::strb_width-1:0]  slave_w_strb,
    input  logic [slave_count*axi_xbar_pkg::resp_width-1:0]  slave_b_resp, slave_r_resp,
    input  logic [slave_count-1:0] slave_aw_valid, slave_aw_ready, slave_w_last,
        slave_w_valid, slave_w_ready, slave_b_valid, slave_b_ready, slave_ar_valid,
        slave_ar_ready, slave_r_last, slave_r_valid, slave_r_ready,

    output int cycle_count,
    output int error_count
);

    localparam int id_w    = axi_xbar_pkg::id_width;
    localparam int addr_w  = axi_xbar_pkg::addr_width;
    localparam int len_w   = axi_xbar_pkg::len_width;
    localparam int size_w  = axi_xbar_pkg::size_width;
    localparam int burst_w = axi_xbar_pkg::burst_width;
    localparam int prot_w  = axi_xbar_pkg::prot_width;
    localparam int data_w  = axi_xbar_pkg::data_width;
    localparam int strb_w  = axi_xbar_pkg::strb_width;
    localparam int resp_w  = axi_xbar_pkg::resp_width;
    // room for the widest flat vector
    localparam int wide = slave_count * (addr_w > data_w ? addr_w : data_w);

    int errors = 0;
    int cycles = 0;

    assign error_count = errors;
    assign cycle_count = cycles;

    function automatic int lowest_set(input logic [slave_count-1:0] sel);
        for (int i = 0; i < slave_count; i++) begin
            if (((sel >> i) & 1) != 0) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic [63:0] lane_field(input logic [wide-1:0] vec, input int lane,
                                               input int width);
        logic [wide-1:0] mask;
        mask = wide'({64{1'b1}} >> (64 - width));
        return 64'((vec >> (lane * width)) & mask);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_lane(input string name, input int lane, input logic [63:0] expected,
                              input logic [wide-1:0] vec, input int width);
        check_value($sformatf("%s[%0d]", name, lane), expected, lane_field(vec, lane, width));
    endtask

    always @(negedge clk) begin
        logic wr_on;
        logic rd_on;
        int wr_idx;
        int rd_idx;
        logic [63:0] wm;
        logic [63:0] rm;
        wr_on  = !reset && (wr_select != '0);
        rd_on  = !reset && (rd_select != '0);
        wr_idx = lowest_set(wr_select);
        rd_idx = lowest_set(rd_select);

        for (int k = 0; k < slave_count; k++) begin
            // all ones on the granted lane and zeros elsewhere
            wm = (wr_on && k == wr_idx) ? '1 : '0;
            rm = (rd_on && k == rd_idx) ? '1 : '0;
            check_lane("slave_aw_id", k, 64'(master_aw_id) & wm, wide'(slave_aw_id), id_w);
            check_lane("slave_aw_addr", k, master_aw_addr & wm, wide'(slave_aw_addr), addr_w);
            check_lane("slave_aw_len", k, 64'(master_aw_len) & wm, wide'(slave_aw_len), len_w);
            check_lane("slave_aw_size", k, 64'(master_aw_size) & wm, wide'(slave_aw_size), size_w);
            check_lane("slave_aw_burst", k, 64'(master_aw_burst) & wm, wide'(slave_aw_burst),
                burst_w);
            check_lane("slave_aw_prot", k, 64'(master_aw_prot) & wm, wide'(slave_aw_prot), prot_w);
            check_lane("slave_aw_valid", k, 64'(master_aw_valid) & wm, wide'(slave_aw_valid), 1);
            check_lane("slave_w_data", k, master_w_data & wm, wide'(slave_w_data), data_w);
            check_lane("slave_w_strb", k, 64'(master_w_strb) & wm, wide'(slave_w_strb), strb_w);
            check_lane("slave_w_last", k, 64'(master_w_last) & wm, wide'(slave_w_last), 1);
            check_lane("slave_w_valid", k, 64'(master_w_valid) & wm, wide'(slave_w_valid), 1);
            check_lane("slave_b_ready", k, 64'(master_b_ready) & wm, wide'(slave_b_ready), 1);
            check_lane("slave_ar_id", k, 64'(master_ar_id) & rm, wide'(slave_ar_id), id_w);
            check_lane("slave_ar_addr", k, master_ar_addr & rm, wide'(slave_ar_addr), addr_w);
            check_lane("slave_ar_len", k, 64'(master_ar_len) & rm, wide'(slave_ar_len), len_w);
            check_lane("slave_ar_size", k, 64'(master_ar_size) & rm, wide'(slave_ar_size), size_w);
            check_lane("slave_ar_burst", k, 64'(master_ar_burst) & rm, wide'(slave_ar_burst),
                burst_w);
            check_lane("slave_ar_prot", k, 64'(master_ar_prot) & rm, wide'(slave_ar_prot), prot_w);
            check_lane("slave_ar_valid", k, 64'(master_ar_valid) & rm, wide'(slave_ar_valid), 1);
            check_lane("slave_r_ready", k, 64'(master_r_ready) & rm, wide'(slave_r_ready), 1);
        end

        // return path from the granted lane or idle values
        check_value("master_aw_ready",
            wr_on ? lane_field(wide'(slave_aw_ready), wr_idx, 1) : 64'd1, 64'(master_aw_ready));
        check_value("master_w_ready",
            wr_on ? lane_field(wide'(slave_w_ready), wr_idx, 1) : 64'd1, 64'(master_w_ready));
        check_value("master_b_id",
            wr_on ? lane_field(wide'(slave_b_id), wr_idx, id_w) : 64'd0, 64'(master_b_id));
        check_value("master_b_resp",
            wr_on ? lane_field(wide'(slave_b_resp), wr_idx, resp_w) : 64'd0, 64'(master_b_resp));
        check_value("master_b_valid",
            wr_on ? lane_field(wide'(slave_b_valid), wr_idx, 1) : 64'd0, 64'(master_b_valid));
        check_value("master_ar_ready",
            rd_on ? lane_field(wide'(slave_ar_ready), rd_idx, 1) : 64'd1, 64'(master_ar_ready));
        check_value("master_r_id",
            rd_on ? lane_field(wide'(slave_r_id), rd_idx, id_w) : 64'd0, 64'(master_r_id));
        check_value("master_r_data",
            rd_on ? lane_field(wide'(slave_r_data), rd_idx, data_w) : 64'd0, master_r_data);
        check_value("master_r_resp",
            rd_on ? lane_field(wide'(slave_r_resp), rd_idx, resp_w) : 64'd0, 64'(master_r_resp));
        check_value("master_r_last",
            rd_on ? lane_field(wide'(slave_r_last), rd_idx, 1) : 64'd0, 64'(master_r_last));
        check_value("master_r_valid",
            rd_on ? lane_field(wide'(slave_r_valid), rd_idx, 1) : 64'd0, 64'(master_r_valid));

        cycles++;
    end

endmodule

`default_nettype wire

// ==== verification/tb_axi_crossbar.sv ====
/* Testbench for the AXI crossbar. Drives seeded random values on every DUT
   input while xbar_checker compares all outputs with its model. */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_crossbar;

    localparam int slave_count = 3;
    localparam int id_w    = axi_xbar_pkg::id_width;
    localparam int addr_w  = axi_xbar_pkg::addr_width;
    localparam int data_w  = axi_xbar_pkg::data_width;
    localparam int strb_w  = axi_xbar_pkg::strb_width;
    localparam int len_w   = axi_xbar_pkg::len_width;
    localparam int size_w  = axi_xbar_pkg::size_width;
    localparam int burst_w = axi_xbar_pkg::burst_width;
    localparam int prot_w  = axi_xbar_pkg::prot_width;
    localparam int resp_w  = axi_xbar_pkg::resp_width;

    localparam int run_cycles    = 2000;
    localparam int drain_timeout = 10;

    logic clk;
    logic reset;
    logic [slave_count-1:0] wr_select, rd_select;

    // master side
    logic [id_w-1:0]    master_aw_id, master_b_id, master_ar_id, master_r_id;
    logic [addr_w-1:0]  master_aw_addr, master_ar_addr;
    logic [len_w-1:0]   master_aw_len, master_ar_len;
    logic [size_w-1:0]  master_aw_size, master_ar_size;
    logic [burst_w-1:0] master_aw_burst, master_ar_burst;
    logic [prot_w-1:0]  master_aw_prot, master_ar_prot;
    logic [data_w-1:0]  master_w_data, master_r_data;
    logic [strb_w-1:0]  master_w_strb;
    logic [resp_w-1:0]  master_b_resp, master_r_resp;
    logic master_aw_valid, master_aw_ready, master_w_last, master_w_valid, master_w_ready;
    logic master_b_valid, master_b_ready, master_ar_valid, master_ar_ready;
    logic master_r_last, master_r_valid, master_r_ready;

    // slave side with lane k in slice k
    logic [slave_count*id_w-1:0]    slave_aw_id, slave_b_id, slave_ar_id, slave_r_id;
    logic [slave_count*addr_w-1:0]  slave_aw_addr, slave_ar_addr;
    logic [slave_count*len_w-1:0]   slave_aw_len, slave_ar_len;
    logic [slave_count*size_w-1:0]  slave_aw_size, slave_ar_size;
    logic [slave_count*burst_w-1:0] slave_aw_burst, slave_ar_burst;
    logic [slave_count*prot_w-1:0]  slave_aw_prot, slave_ar_prot;
    logic [slave_count*data_w-1:0]  slave_w_data, slave_r_data;
    logic [slave_count*strb_w-1:0]  slave_w_strb;
    logic [slave_count*resp_w-1:0]  slave_b_resp, slave_r_resp;
    logic [slave_count-1:0] slave_aw_valid, slave_aw_ready, slave_w_last, slave_w_valid;
    logic [slave_count-1:0] slave_w_ready, slave_b_valid, slave_b_ready;
    logic [slave_count-1:0] slave_ar_valid, slave_ar_ready;
    logic [slave_count-1:0] slave_r_last, slave_r_valid, slave_r_ready;

    int cycle_count;
    int error_count;

    axi_crossbar #(
        .slave_count(slave_count)
    ) i_dut (.*);

    xbar_checker #(
        .slave_count(slave_count)
    ) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // zero, one-hot and multi-bit words in roughly equal share
    function automatic logic [slave_count-1:0] pick_select();
        logic [slave_count-1:0] first;
        logic [slave_count-1:0] second;
        first  = slave_count'(1) << ($urandom % slave_count);
        second = slave_count'(1) << ($urandom % slave_count);
        case ($urandom % 4)
            0: return '0;
            1: return first;
            2: return first | second;
            default: return slave_count'($urandom);
        endcase
    endfunction

    task automatic drive_random();
        wr_select       = pick_select();
        rd_select       = pick_select();
        master_aw_id    = id_w'($urandom);
        master_aw_addr  = {$urandom, $urandom};
        master_aw_len   = len_w'($urandom);
        master_aw_size  = size_w'($urandom);
        master_aw_burst = burst_w'($urandom);
        master_aw_prot  = prot_w'($urandom);
        master_aw_valid = 1'($urandom);
        master_w_data   = {$urandom, $urandom};
        master_w_strb   = strb_w'($urandom);
        master_w_last   = 1'($urandom);
        master_w_valid  = 1'($urandom);
        master_b_ready  = 1'($urandom);
        master_ar_id    = id_w'($urandom);
        master_ar_addr  = {$urandom, $urandom};
        master_ar_len   = len_w'($urandom);
        master_ar_size  = size_w'($urandom);
        master_ar_burst = burst_w'($urandom);
        master_ar_prot  = prot_w'($urandom);
        master_ar_valid = 1'($urandom);
        master_r_ready  = 1'($urandom);
        slave_aw_ready  = slave_count'($urandom);
        slave_w_ready   = slave_count'($urandom);
        slave_b_valid   = slave_count'($urandom);
        slave_ar_ready  = slave_count'($urandom);
        slave_r_last    = slave_count'($urandom);
        slave_r_valid   = slave_count'($urandom);
        for (int k = 0; k < slave_count; k++) begin
            slave_b_id[k*id_w +: id_w]       = id_w'($urandom);
            slave_b_resp[k*resp_w +: resp_w] = resp_w'($urandom);
            slave_r_id[k*id_w +: id_w]       = id_w'($urandom);
            slave_r_data[k*data_w +: data_w] = {$urandom, $urandom};
            slave_r_resp[k*resp_w +: resp_w] = resp_w'($urandom);
        end
    endtask

    initial begin
        int target;
        int waited;
        void'($urandom(32'hac7b));
        reset = 1'b1;
        drive_random();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            drive_random();
        end

        for (int i = 0; i < run_cycles; i++) begin
            @(posedge clk);
            #1;
            // second reset pulse half way through
            reset = (i >= 1000 && i < 1004);
            drive_random();
        end

        // let the checker sample the last values
        target = cycle_count + 1;
        waited = 0;
        while (cycle_count < target && waited < drain_timeout) begin
            @(posedge clk);
            waited++;
        end

        if (cycle_count < target) begin
            $display("timeout: checker did not sample the final inputs within %0d cycles",
                drain_timeout);
            $display("Errors found");
        end else begin
            $display("cycles checked: %0d, errors: %0d", cycle_count, error_count);
            if (error_count == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/axi_xbar_pkg.sv
hw/port_select.sv
hw/write_router.sv
hw/read_router.sv
hw/axi_crossbar.sv
verification/xbar_checker.sv
verification/tb_axi_crossbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the crossbar testbench with Verilator and runs it.
# Exit status is zero only when the run reports the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_axi_crossbar -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_axi_crossbar)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
